/* hw/gb_pkg.sv */
// system bus package for the handheld console glue logic
// address regions, i/o register codes, bus structs and fixed values
package gb_pkg;

	// ------------------------------------------------------------
	// fixed values
	// ------------------------------------------------------------
	localparam logic [7:0] IRQ_VEC_BASE    = 8'h40; // vblank vector
	localparam int         IRQ_VEC_STEP    = 8;     // spacing between vectors
	localparam logic [7:0] BOOT_OFF_GBC    = 8'h11; // ff50 value on colour model
	localparam logic [2:0] WRAM_BANK_RESET = 3'd1;
	localparam logic [7:0] OPEN_BUS_FF     = 8'hFF; // pulled-up bus

	// ------------------------------------------------------------
	// enums
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		REGION_ROM,   // 0000-7fff
		REGION_VRAM,  // 8000-9fff
		REGION_CRAM,  // a000-bfff
		REGION_WRAM,  // c000-fdff incl echo
		REGION_OAM,   // fe00-fe9f
		REGION_IO,    // ff00-ff7f and ffff
		REGION_ZPRAM, // ff80-fffe
		REGION_NONE   // fea0-feff
	} gb_region_e;

	typedef enum logic [3:0] {
		IO_P1, IO_IF, IO_IE, IO_KEY0, IO_KEY1, IO_VBK, IO_SVBK,
		IO_BOOT, IO_FF72, IO_FF73, IO_FF74, IO_FF75, IO_OTHER
	} gb_ioreg_e;

	// bit index in if/ie, lowest wins
	typedef enum logic [2:0] {
		IRQ_VBLANK, IRQ_LCDC, IRQ_TIMER, IRQ_SERIAL, IRQ_JOYPAD
	} gb_irq_e;

	// ------------------------------------------------------------
	// structs
	// ------------------------------------------------------------
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;   // cpu write data
		logic        rd_n;
		logic        wr_n;
		logic        iorq_n;
		logic        m1_n;
	} cpu_bus_t;

	typedef struct packed {
		gb_region_e region;
		gb_ioreg_e  ioreg;
		logic       wr_stb; // one cycle per write
		logic       rd;
		logic       ack;    // irq acknowledge cycle
	} bus_sel_t;

	typedef struct packed {
		logic vblank;
		logic lcdc;
		logic timer;
		logic serial;
	} irq_events_t;

	typedef struct packed {
		logic [1:0] key0;
		logic       gbc_mode;
		logic       boot_en;
		logic       speed;
		logic       prepare;
		logic [2:0] wram_bank;
		logic       vram_bank;
		logic [1:0] p54;
	} sys_state_t;

	typedef struct packed {
		logic [14:0] addr;
		logic        a15;
		logic        rd;
		logic        wr;
		logic        ncs;  // cram / wram chip select, low active
		logic [7:0]  din;
	} cart_bus_t;

endpackage

/* hw/gb_addr_decode.sv */
// cpu address decoder
// maps the address to a region and an i/o register code
// and turns the write level into a one-cycle strobe
`timescale 1ns/1ns

module gb_addr_decode (
	input  logic                clk_sys,
	input  logic                reset_ss,
	input  gb_pkg::cpu_bus_t    cpu_bus_i,
	input  logic                is_gbc_i,
	input  gb_pkg::sys_state_t  state_i,
	output gb_pkg::bus_sel_t    sel_o
);
	import gb_pkg::*;

	logic [15:0] a;
	logic        wr_n_q; // wr_n one cycle back
	gb_region_e  region;
	gb_ioreg_e   ioreg;

	assign a = cpu_bus_i.addr;

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			wr_n_q <= 1'b0;
		else
			wr_n_q <= cpu_bus_i.wr_n;
	end

	// region map
	always_comb begin
		region = REGION_NONE;
		if (!a[15])
			region = REGION_ROM;
		else if (a[15:13] == 3'b100)
			region = REGION_VRAM;
		else if (a[15:13] == 3'b101)
			region = REGION_CRAM;
		else if (a[15:14] == 2'b11 && !(&a[13:9]))
			region = REGION_WRAM; // echo at e000 lands here too
		else if (a[15:8] == 8'hFE) begin
			if (a[7:0] < 8'hA0)
				region = REGION_OAM;
		end else if (a == 16'hFFFF || !a[7])
			region = REGION_IO;   // ie sits at the very top
		else
			region = REGION_ZPRAM;
	end

	// i/o registers, colour ones qualified by model and mode
	always_comb begin
		ioreg = IO_OTHER;
		case (a)
			16'hFF00: ioreg = IO_P1;
			16'hFF0F: ioreg = IO_IF;
			16'hFFFF: ioreg = IO_IE;
			16'hFF4C: if (is_gbc_i && state_i.boot_en) ioreg = IO_KEY0;
			16'hFF4D: if (state_i.gbc_mode) ioreg = IO_KEY1;
			16'hFF4F: if (is_gbc_i) ioreg = IO_VBK;
			16'hFF50: ioreg = IO_BOOT;
			16'hFF70: if (state_i.gbc_mode) ioreg = IO_SVBK;
			16'hFF72: if (is_gbc_i) ioreg = IO_FF72;
			16'hFF73: if (is_gbc_i) ioreg = IO_FF73;
			16'hFF74: if (is_gbc_i) ioreg = IO_FF74;
			16'hFF75: if (is_gbc_i) ioreg = IO_FF75;
			default:  ioreg = IO_OTHER;
		endcase
	end

	assign sel_o.region = region;
	assign sel_o.ioreg  = ioreg;
	assign sel_o.wr_stb = wr_n_q & ~cpu_bus_i.wr_n; // high to low
	assign sel_o.rd     = ~cpu_bus_i.rd_n;
	assign sel_o.ack    = ~cpu_bus_i.iorq_n & ~cpu_bus_i.m1_n;

endmodule

/* hw/gb_irq_ctrl.sv */
// interrupt controller
// if/ie registers, event edge capture, priority vector
// and clear of the serviced flag at the end of an ack cycle
`timescale 1ns/1ns

module gb_irq_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset_ss,
	input  gb_pkg::bus_sel_t     sel_i,
	input  logic [7:0]           wdata_i,
	input  gb_pkg::irq_events_t  events_i,
	input  logic [3:0]           joy_din_i,
	output logic [4:0]           if_o,
	output logic [7:0]           ie_o,
	output logic [7:0]           vector_o,
	output logic                 irq_n_o
);
	import gb_pkg::*;

	logic [4:0] if_r;
	logic [4:0] if_next;
	logic [7:0] ie_r;  // all 8 bits r/w
	logic [3:0] ev;
	logic [3:0] ev_q;
	logic [3:0] ev_rise;
	logic [3:0] joy_s1, joy_s2, joy_s3;
	logic       ack_q;
	logic [4:0] pend;
	logic       irq_any;
	gb_irq_e    irq_idx;

	// same order as the if bits
	assign ev      = {events_i.serial, events_i.timer, events_i.lcdc, events_i.vblank};
	assign ev_rise = ev & ~ev_q;
	assign pend    = if_r & ie_r[4:0];

	// lowest pending bit wins
	always_comb begin
		irq_idx = IRQ_VBLANK;
		irq_any = 1'b0;
		for (int i = 4; i >= 0; i--) begin
			if (pend[i]) begin
				irq_idx = gb_irq_e'(3'(i));
				irq_any = 1'b1;
			end
		end
	end

	assign vector_o = irq_any ? IRQ_VEC_BASE + 8'(IRQ_VEC_STEP * int'(irq_idx)) : 8'h00;
	assign irq_n_o  = ~irq_any;

	// ------------------------------------------------------------
	// next flag value
	// ------------------------------------------------------------
	always_comb begin
		if_next      = if_r;
		if_next[3:0] = if_r[3:0] | ev_rise;          // low to high sets
		if (|(~joy_s2 & joy_s3))
			if_next[IRQ_JOYPAD] = 1'b1;              // any p10..p13 falling
		if (ack_q && !sel_i.ack && irq_any)
			if_next[irq_idx] = 1'b0;                 // serviced one
		if (sel_i.wr_stb && sel_i.ioreg == IO_IF)
			if_next = wdata_i[4:0];                  // cpu write wins
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r   <= 5'd0;
			ie_r   <= 8'd0;
			ev_q   <= 4'd0;
			joy_s1 <= 4'd0;
			joy_s2 <= 4'd0;
			joy_s3 <= 4'd0;
			ack_q  <= 1'b0;
		end else begin
			ev_q   <= ev;
			joy_s1 <= joy_din_i; // two sync stages
			joy_s2 <= joy_s1;
			joy_s3 <= joy_s2;    // edge reference
			ack_q  <= sel_i.ack;
			if_r   <= if_next;
			if (sel_i.wr_stb && sel_i.ioreg == IO_IE)
				ie_r <= wdata_i;
		end
	end

	assign if_o = if_r;
	assign ie_o = ie_r;

endmodule

/* hw/gb_sys_regs.sv */
// colour model system registers
// key0, key1 speed switch, svbk, vbk, spare ff72-ff75,
// joypad select and the boot rom disable latch
`timescale 1ns/1ns

module gb_sys_regs (
	input  logic                clk_sys,
	input  logic                reset_ss,
	input  gb_pkg::bus_sel_t    sel_i,
	input  logic [7:0]          wdata_i,
	input  logic                is_gbc_i,
	input  logic                stop_i,
	output gb_pkg::sys_state_t  state_o,
	output logic [26:0]         spare_o,
	output logic                speed_o,
	output logic [1:0]          joy_p54_o
);
	import gb_pkg::*;

	logic [1:0] key0;      // cpu mode, 00 means cgb
	logic       boot_en;
	logic       speed;     // 1 = double speed
	logic       prepare;
	logic [2:0] wram_bank;
	logic       vram_bank;
	logic [1:0] p54;
	logic [7:0] ff72, ff73, ff74;
	logic [2:0] ff75;      // only bits 6:4 exist
	logic       boot_off;

	// 11h on colour model, any odd value otherwise
	assign boot_off = is_gbc_i ? (wdata_i == BOOT_OFF_GBC) : wdata_i[0];

	// ------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			key0      <= 2'd0;
			boot_en   <= 1'b1;
			speed     <= 1'b0;
			prepare   <= 1'b0;
			wram_bank <= WRAM_BANK_RESET;
			vram_bank <= 1'b0;
			p54       <= 2'd0;
			ff72      <= 8'd0;
			ff73      <= 8'd0;
			ff74      <= 8'd0;
			ff75      <= 3'd0;
		end else begin
			if (sel_i.wr_stb) begin
				case (sel_i.ioreg)
					IO_KEY0: key0 <= wdata_i[3:2];
					IO_KEY1: prepare <= wdata_i[0];
					IO_SVBK: wram_bank <= (wdata_i[2:0] == 3'd0) ? 3'd1 : wdata_i[2:0];
					IO_VBK:  vram_bank <= wdata_i[0];
					IO_P1:   p54 <= wdata_i[5:4];
					IO_BOOT: if (boot_off) boot_en <= 1'b0; // one-way latch
					IO_FF72: ff72 <= wdata_i;
					IO_FF73: ff73 <= wdata_i;
					IO_FF74: ff74 <= wdata_i;
					IO_FF75: ff75 <= wdata_i[6:4];
					default: ;
				endcase
			end
			// stop with prepare armed flips the speed
			if (prepare && stop_i && is_gbc_i) begin
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	assign state_o.key0      = key0;
	assign state_o.gbc_mode  = (key0 == 2'd0) | boot_en;
	assign state_o.boot_en   = boot_en;
	assign state_o.speed     = speed;
	assign state_o.prepare   = prepare;
	assign state_o.wram_bank = wram_bank;
	assign state_o.vram_bank = vram_bank;
	assign state_o.p54       = p54;

	assign spare_o   = {ff72, ff73, ff74, ff75};
	assign speed_o   = speed;
	assign joy_p54_o = p54;

endmodule

/* hw/gb_ext_bus.sv */
// external cartridge bus
// strobes, chip select, a15 override, banked wram address
// and the open bus latch with its slow pull-up decay
`timescale 1ns/1ns

module gb_ext_bus #(
	parameter int OPEN_BUS_DECAY = 4
) (
	input  logic                clk_sys,
	input  logic                reset_ss,
	input  gb_pkg::cpu_bus_t    cpu_bus_i,
	input  gb_pkg::bus_sel_t    sel_i,
	input  gb_pkg::sys_state_t  state_i,
	input  logic [7:0]          cart_do_i,
	input  logic                cart_oe_i,
	output gb_pkg::cart_bus_t   cart_o,
	output logic [14:0]         wram_addr_o,
	output logic [7:0]          ext_di_o
);
	import gb_pkg::*;

	localparam int CNT_MAX = OPEN_BUS_DECAY + 1;
	localparam int CW      = $clog2(CNT_MAX + 1);

	logic [15:0]   a;
	logic          ext_sel;
	logic          ram_sel;   // cram or wram
	logic          driven;    // someone drives the data lines
	logic [7:0]    open_bus_data;
	logic [CW-1:0] open_bus_cnt;

	assign a       = cpu_bus_i.addr;
	assign ram_sel = (sel_i.region == REGION_CRAM) | (sel_i.region == REGION_WRAM);
	assign ext_sel = (sel_i.region == REGION_ROM) | ram_sel;
	assign driven  = ext_sel & cart_oe_i;

	// ------------------------------------------------------------
	// cartridge pins
	// ------------------------------------------------------------
	assign cart_o.addr = a[14:0];
	assign cart_o.a15  = a[15] | (state_i.boot_en && a[15:8] == 8'h00); // boot rom shadow
	assign cart_o.rd   = ext_sel & sel_i.rd;
	assign cart_o.wr   = ext_sel & sel_i.wr_stb;
	assign cart_o.ncs  = ~ram_sel;
	assign cart_o.din  = cpu_bus_i.dout;

	// d000 page takes the svbk bank
	assign wram_addr_o = a[12] ? {state_i.wram_bank, a[11:0]} : {3'd0, a[11:0]};

	assign ext_di_o = driven ? cart_do_i : open_bus_data;

	// ------------------------------------------------------------
	// open bus: last byte holds, then decays to ff
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			open_bus_data <= OPEN_BUS_FF;
			open_bus_cnt  <= CW'(CNT_MAX); // start decayed
		end else begin
			open_bus_data <= ext_di_o;
			if (driven)
				open_bus_cnt <= '0;
			else if (open_bus_cnt != CW'(CNT_MAX)) begin
				open_bus_cnt <= open_bus_cnt + 1'b1;
				if (open_bus_cnt == CW'(OPEN_BUS_DECAY))
					open_bus_data <= OPEN_BUS_FF;
			end
		end
	end

endmodule

/* hw/gb_read_mux.sv */
// cpu read data mux
// picks the byte returned to the cpu, unused bits read as 1
`timescale 1ns/1ns

module gb_read_mux (
	input  gb_pkg::bus_sel_t    sel_i,
	input  logic                is_gbc_i,
	input  gb_pkg::sys_state_t  state_i,
	input  logic [4:0]          if_i,
	input  logic [7:0]          ie_i,
	input  logic [7:0]          vector_i,
	input  logic [26:0]         spare_i,
	input  logic [3:0]          joy_din_i,
	input  logic [7:0]          ext_di_i,
	output logic [7:0]          cpu_di_o
);
	import gb_pkg::*;

	logic ext_sel;

	assign ext_sel = (sel_i.region == REGION_ROM) | (sel_i.region == REGION_CRAM)
		| (sel_i.region == REGION_WRAM);

	always_comb begin
		cpu_di_o = OPEN_BUS_FF;
		if (sel_i.ack)
			cpu_di_o = vector_i; // rst vector during ack
		else begin
			case (sel_i.ioreg)
				IO_IF:   cpu_di_o = {3'b111, if_i};
				IO_IE:   cpu_di_o = ie_i;
				IO_KEY0: cpu_di_o = {4'hF, state_i.key0, 2'b10};
				IO_KEY1: cpu_di_o = {state_i.speed, 6'h3F, state_i.prepare};
				IO_SVBK: cpu_di_o = {5'h1F, state_i.wram_bank};
				IO_VBK:  if (is_gbc_i) cpu_di_o = {7'h7F, state_i.vram_bank};
				IO_P1:   cpu_di_o = {2'b11, state_i.p54, joy_din_i};
				IO_FF72: if (is_gbc_i) cpu_di_o = spare_i[26:19];
				IO_FF73: if (is_gbc_i) cpu_di_o = spare_i[18:11];
				IO_FF74: if (is_gbc_i) cpu_di_o = spare_i[10:3];
				IO_FF75: if (is_gbc_i) cpu_di_o = {1'b1, spare_i[2:0], 4'hF};
				default: begin
					if (ext_sel)
						cpu_di_o = ext_di_i; // rom, cram, wram
				end
			endcase
		end
	end

endmodule

/* hw/gb_sysbus.sv */
// system bus top level
// address decode, interrupt controller, system registers,
// cartridge bus and cpu read mux
`timescale 1ns/1ns

module gb_sysbus #(
	parameter int OPEN_BUS_DECAY = 4
) (
	input  logic                 clk_sys,
	input  logic                 reset_ss,
	input  gb_pkg::cpu_bus_t     cpu_bus_i,
	input  logic                 is_gbc_i,
	input  logic                 stop_i,
	input  gb_pkg::irq_events_t  irq_events_i,
	input  logic [3:0]           joy_din_i,
	input  logic [7:0]           cart_do_i,
	input  logic                 cart_oe_i,
	output logic [7:0]           cpu_di_o,
	output logic                 irq_n_o,
	output logic                 speed_o,
	output logic [1:0]           joy_p54_o,
	output gb_pkg::cart_bus_t    cart_o,
	output logic [14:0]          wram_addr_o
);
	import gb_pkg::*;

	bus_sel_t    sel;
	sys_state_t  state;
	logic [4:0]  if_w;
	logic [7:0]  ie_w;
	logic [7:0]  vector;
	logic [26:0] spare;   // ff72..ff75 packed
	logic [7:0]  ext_di;

	// ------------------------------------------------------------
	// decode and registers
	// ------------------------------------------------------------
	gb_addr_decode u_decode (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.cpu_bus_i (cpu_bus_i),
		.is_gbc_i  (is_gbc_i),
		.state_i   (state),
		.sel_o     (sel)
	);

	gb_irq_ctrl u_irq (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.sel_i     (sel),
		.wdata_i   (cpu_bus_i.dout),
		.events_i  (irq_events_i),
		.joy_din_i (joy_din_i),
		.if_o      (if_w),
		.ie_o      (ie_w),
		.vector_o  (vector),
		.irq_n_o   (irq_n_o)
	);

	gb_sys_regs u_regs (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.sel_i     (sel),
		.wdata_i   (cpu_bus_i.dout),
		.is_gbc_i  (is_gbc_i),
		.stop_i    (stop_i),
		.state_o   (state),
		.spare_o   (spare),
		.speed_o   (speed_o),
		.joy_p54_o (joy_p54_o)
	);

	// ------------------------------------------------------------
	// cartridge side and read path
	// ------------------------------------------------------------
	gb_ext_bus #(
		.OPEN_BUS_DECAY (OPEN_BUS_DECAY)
	) u_ext (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.cpu_bus_i   (cpu_bus_i),
		.sel_i       (sel),
		.state_i     (state),
		.cart_do_i   (cart_do_i),
		.cart_oe_i   (cart_oe_i),
		.cart_o      (cart_o),
		.wram_addr_o (wram_addr_o),
		.ext_di_o    (ext_di)
	);

	gb_read_mux u_rmux (
		.sel_i     (sel),
		.is_gbc_i  (is_gbc_i),
		.state_i   (state),
		.if_i      (if_w),
		.ie_i      (ie_w),
		.vector_i  (vector),
		.spare_i   (spare),
		.joy_din_i (joy_din_i),
		.ext_di_i  (ext_di),
		.cpu_di_o  (cpu_di_o)
	);

endmodule

/* bench/tb_gb_sysbus.sv */
// testbench for the system bus top level
// drives the cpu bus on the falling edge and checks reads,
// interrupts, speed switch, boot latch and the cartridge bus
`timescale 1ns/1ns

module tb_gb_sysbus;
	import gb_pkg::*;

	localparam int DECAY = 4;

	logic        clk_sys;
	logic        reset_ss;
	cpu_bus_t    cpu_bus;
	logic        is_gbc;
	logic        stop;
	irq_events_t events;
	logic [3:0]  joy_din;
	logic [7:0]  cart_do;
	logic        cart_oe;
	logic [7:0]  cpu_di;
	logic        irq_n;
	logic        speed;
	logic [1:0]  joy_p54;
	cart_bus_t   cart;
	logic [14:0] wram_addr;

	// register model
	logic [4:0]  if_m;
	logic [7:0]  ie_m;
	logic [1:0]  key0_m;
	logic        boot_en_m, speed_m, prepare_m, vbk_m;
	logic [2:0]  svbk_m, ff75_m;
	logic [1:0]  p54_m;
	logic [7:0]  ff72_m, ff73_m, ff74_m;
	logic [15:0] lfsr;
	logic [15:0] addr;
	logic [7:0]  data, held;
	logic        ext;
	int          n;

	gb_sysbus #(.OPEN_BUS_DECAY(DECAY)) UUT (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .cpu_bus_i(cpu_bus),
		.is_gbc_i(is_gbc), .stop_i(stop), .irq_events_i(events),
		.joy_din_i(joy_din), .cart_do_i(cart_do), .cart_oe_i(cart_oe),
		.cpu_di_o(cpu_di), .irq_n_o(irq_n), .speed_o(speed),
		.joy_p54_o(joy_p54), .cart_o(cart), .wram_addr_o(wram_addr)
	);

	always #10 clk_sys = ~clk_sys; // 20 ns period

	// ----------------------------------------------------------
	// random source and reference model
	// ----------------------------------------------------------
	function automatic logic [15:0] rand_bits(input int nbits);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x16+x14+x13+x11
			lfsr = {lfsr[14:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic logic gbc_mode_m();
		return (key0_m == 2'd0) || boot_en_m;
	endfunction

	function automatic logic [7:0] exp_vector();
		logic [4:0] p;
		p = if_m & ie_m[4:0];
		for (int i = 0; i < 5; i++)
			if (p[i])
				return 8'h40 + 8'(8 * i);
		return 8'h00;
	endfunction

	// expected cpu_di for register and unmapped addresses
	function automatic logic [7:0] exp_read(input logic [15:0] a);
		case (a)
			16'hFF0F: return {3'b111, if_m};
			16'hFFFF: return ie_m;
			16'hFF00: return {2'b11, p54_m, joy_din};
			16'hFF4C: return (is_gbc && boot_en_m) ? {4'hF, key0_m, 2'b10} : 8'hFF;
			16'hFF4D: return gbc_mode_m() ? {speed_m, 6'h3F, prepare_m} : 8'hFF;
			16'hFF4F: return is_gbc ? {7'h7F, vbk_m} : 8'hFF;
			16'hFF70: return gbc_mode_m() ? {5'h1F, svbk_m} : 8'hFF;
			16'hFF72: return is_gbc ? ff72_m : 8'hFF;
			16'hFF73: return is_gbc ? ff73_m : 8'hFF;
			16'hFF74: return is_gbc ? ff74_m : 8'hFF;
			16'hFF75: return is_gbc ? {1'b1, ff75_m, 4'hF} : 8'hFF;
			default:  return 8'hFF;
		endcase
	endfunction

	function automatic logic is_ext(input logic [15:0] a);
		return (a < 16'h8000) || (a >= 16'hA000 && a < 16'hFE00);
	endfunction

	function automatic cart_bus_t exp_cart(input logic [15:0] a, input logic rd,
		input logic wr, input logic [7:0] dout);
		cart_bus_t e;
		e.addr = a[14:0];
		e.a15  = a[15] | (boot_en_m && a < 16'h0100); // boot rom overlay
		e.rd   = is_ext(a) & rd;
		e.wr   = is_ext(a) & wr;
		e.ncs  = !(is_ext(a) && a >= 16'hA000);
		e.din  = dout;
		return e;
	endfunction

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			abort_run("byte compare failed");
		end
	endtask

	task automatic check_cart(input string name, input cart_bus_t exp, input cart_bus_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			abort_run("cartridge bus compare failed");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			abort_run("bit compare failed");
		end
	endtask

	// ----------------------------------------------------------
	// bus helpers
	// ----------------------------------------------------------
	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cpu_bus.addr = a;
		cpu_bus.dout = d;
		cpu_bus.rd_n = 1'b1;
		cpu_bus.wr_n = 1'b0;
		@(negedge clk_sys);
		cpu_bus.wr_n = 1'b1;
		case (a) // model follows the register rules
			16'hFF0F: if_m = d[4:0];
			16'hFFFF: ie_m = d;
			16'hFF00: p54_m = d[5:4];
			16'hFF4C: if (is_gbc && boot_en_m) key0_m = d[3:2];
			16'hFF4D: if (gbc_mode_m()) prepare_m = d[0];
			16'hFF4F: if (is_gbc) vbk_m = d[0];
			16'hFF50: if (is_gbc ? (d == 8'h11) : d[0]) boot_en_m = 1'b0;
			16'hFF70: if (gbc_mode_m()) svbk_m = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
			16'hFF72: if (is_gbc) ff72_m = d;
			16'hFF73: if (is_gbc) ff73_m = d;
			16'hFF74: if (is_gbc) ff74_m = d;
			16'hFF75: if (is_gbc) ff75_m = d[6:4];
			default: ;
		endcase
	endtask

	task automatic read_check(input string name, input logic [15:0] a);
		@(negedge clk_sys);
		cpu_bus.addr = a;
		cpu_bus.rd_n = 1'b0;
		#2 check_byte(name, exp_read(a), cpu_di);
	endtask

	// one ack cycle, then the flag it served is cleared
	task automatic ack_check(input string name);
		logic [7:0] v;
		v = exp_vector();
		@(negedge clk_sys);
		cpu_bus.rd_n   = 1'b1;
		cpu_bus.iorq_n = 1'b0;
		cpu_bus.m1_n   = 1'b0;
		#2 check_byte(name, v, cpu_di);
		@(negedge clk_sys);
		cpu_bus.iorq_n = 1'b1;
		cpu_bus.m1_n   = 1'b1;
		if (v != 8'h00)
			if_m = if_m & ~(5'd1 << ((v - 8'h40) >> 3));
	endtask

	task automatic wait_irq_low();
		int t;
		t = 0;
		while (irq_n !== 1'b0) begin
			@(negedge clk_sys);
			t++;
			if (t > 20)
				abort_run("irq_n_o never went low after the events");
		end
	endtask

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------
	initial begin
		clk_sys = 1'b0;
		reset_ss = 1'b1;
		cpu_bus = '{addr: 16'h0000, dout: 8'h00, rd_n: 1'b1, wr_n: 1'b1,
			iorq_n: 1'b1, m1_n: 1'b1};
		is_gbc = 1'b1;
		stop = 1'b0;
		events = '0;
		joy_din = 4'hF;
		cart_do = 8'h00;
		cart_oe = 1'b0;
		lfsr = 16'd35064;
		if_m = '0;
		ie_m = '0;
		key0_m = '0;
		boot_en_m = 1'b1;
		speed_m = 1'b0;
		prepare_m = 1'b0;
		vbk_m = 1'b0;
		svbk_m = 3'd1;
		ff75_m = '0;
		p54_m = '0;
		ff72_m = '0;
		ff73_m = '0;
		ff74_m = '0;
		repeat (10) @(negedge clk_sys);
		reset_ss = 1'b0;
		#2 check_bit("reset irq_n", 1'b1, irq_n);
		check_cart("reset cart", exp_cart(16'h0000, 1'b0, 1'b0, 8'h00), cart);

		// interrupts
		write_reg(16'hFFFF, 8'hFF);
		@(negedge clk_sys);
		events.vblank = 1'b1;
		events.timer  = 1'b1;
		if_m = 5'b00101;
		wait_irq_low();
		ack_check("irq vblank vector");
		read_check("irq if after ack", 16'hFF0F);
		ack_check("irq timer vector");
		joy_din = 4'hE; // p10 pressed
		@(negedge clk_sys);
		cpu_bus.addr = 16'hFF0F;
		cpu_bus.rd_n = 1'b0;
		n = 0;
		#2;
		while (cpu_di[4] !== 1'b1) begin
			@(negedge clk_sys);
			#2;
			n++;
			if (n > 10)
				abort_run("joypad flag never set");
		end
		if_m[4] = 1'b1;
		read_check("irq joypad flag", 16'hFF0F);
		joy_din = 4'hF;
		events = '0;
		write_reg(16'hFF0F, 8'h00);

		// register read-back
		write_reg(16'hFFFF, 8'(rand_bits(8)));
		write_reg(16'hFF72, 8'(rand_bits(8)));
		write_reg(16'hFF73, 8'(rand_bits(8)));
		write_reg(16'hFF74, 8'(rand_bits(8)));
		write_reg(16'hFF75, 8'(rand_bits(8)));
		write_reg(16'hFF4F, 8'h01);
		write_reg(16'hFF00, 8'h20);
		read_check("regs ie", 16'hFFFF);
		read_check("regs ff72", 16'hFF72);
		read_check("regs ff73", 16'hFF73);
		read_check("regs ff74", 16'hFF74);
		read_check("regs ff75", 16'hFF75);
		read_check("regs vbk", 16'hFF4F);
		read_check("regs p1", 16'hFF00);
		check_byte("regs p54 pins", {6'd0, p54_m}, {6'd0, joy_p54});
		write_reg(16'hFF70, 8'h03);
		read_check("regs svbk", 16'hFF70);
		write_reg(16'hFF70, 8'h00);
		read_check("regs svbk zero", 16'hFF70);
		read_check("regs unmapped", 16'hFF10);

		// speed switch
		write_reg(16'hFF4D, 8'h01);
		read_check("speed prepare", 16'hFF4D);
		@(negedge clk_sys);
		stop = 1'b1;
		@(negedge clk_sys);
		stop = 1'b0;
		speed_m = 1'b1;
		prepare_m = 1'b0;
		check_bit("speed pin", 1'b1, speed);
		read_check("speed after stop", 16'hFF4D);
		is_gbc = 1'b0; // colour model off
		write_reg(16'hFF4D, 8'h01);
		@(negedge clk_sys);
		stop = 1'b1;
		@(negedge clk_sys);
		stop = 1'b0;
		check_bit("speed no toggle", 1'b1, speed);
		read_check("speed prepare held", 16'hFF4D);
		write_reg(16'hFF4D, 8'h00);
		is_gbc = 1'b1;

		// boot disable and mode
		read_check("boot key0", 16'hFF4C);
		@(negedge clk_sys);
		cpu_bus.addr = 16'h0050;
		#2 check_cart("boot a15 forced", exp_cart(16'h0050, 1'b1, 1'b0, cpu_bus.dout), cart);
		write_reg(16'hFF50, 8'h01);
		read_check("boot still on", 16'hFF4C);
		write_reg(16'hFF50, 8'h11);
		read_check("boot key0 gone", 16'hFF4C);
		@(negedge clk_sys);
		cpu_bus.addr = 16'h0050;
		#2 check_cart("boot a15 free", exp_cart(16'h0050, 1'b1, 1'b0, cpu_bus.dout), cart);

		// external bus
		write_reg(16'hFF70, 8'h05);
		for (int i = 0; i < 40; i++) begin
			addr = rand_bits(16);
			data = 8'(rand_bits(8));
			ext  = is_ext(addr);
			@(negedge clk_sys);
			cpu_bus.addr = addr;
			cpu_bus.dout = data;
			cpu_bus.rd_n = 1'b0;
			cpu_bus.wr_n = !ext; // writes only where nothing internal changes
			#2 check_cart("ext pins", exp_cart(addr, 1'b1, ext, data), cart);
			if (addr >= 16'hC000 && addr < 16'hFE00) begin
				check_byte("ext wram hi", {1'b0, addr[12] ? svbk_m : 3'd0, addr[11:8]},
					{1'b0, wram_addr[14:8]});
				check_byte("ext wram lo", addr[7:0], wram_addr[7:0]);
			end
			@(negedge clk_sys);
			cpu_bus.wr_n = 1'b1;
		end

		// open bus
		held = 8'(rand_bits(8));
		@(negedge clk_sys);
		cpu_bus.addr = 16'h1234;
		cpu_bus.rd_n = 1'b0;
		cart_do = held;
		cart_oe = 1'b1;
		#2 check_byte("open rom read", held, cpu_di);
		@(negedge clk_sys);
		cpu_bus.addr = 16'hA123;
		cart_oe = 1'b0;
		cart_do = ~held;
		#2 check_byte("open cram held", held, cpu_di);
		n = 0;
		while (n < DECAY + 2) begin
			@(negedge clk_sys);
			n++;
		end
		#2 check_byte("open decayed", 8'hFF, cpu_di);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* tb.f */
hw/gb_pkg.sv
hw/gb_addr_decode.sv
hw/gb_irq_ctrl.sv
hw/gb_sys_regs.sv
hw/gb_ext_bus.sv
hw/gb_read_mux.sv
hw/gb_sysbus.sv
bench/tb_gb_sysbus.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass is judged from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_gb_sysbus -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || exit 1
